/* source/coreTypes.sv */
`default_nettype none

package coreTypes;

        // data widths
        typedef logic [6:0]  opIdT;
        typedef logic [15:0] instrT;
        typedef logic [15:0] wordT;
        typedef logic [2:0]  regAddrT;

        // control field widths
        typedef logic [3:0] aluCtlT;
        typedef logic [3:0] bsCtlT;
        typedef logic [3:0] mdhCtlT;
        typedef logic [2:0] rbCtlT;
        typedef logic [2:0] seCtlT;
        typedef logic [2:0] mahCtlT;
        typedef logic [2:0] emCtlT;
        typedef logic [1:0] ioCtlT;

        typedef enum logic [1:0] {runS, haltS, resetS} runStateT;

        // alu codes, anything unlisted passes A
        localparam aluCtlT aluOr    = 4'd1;
        localparam aluCtlT aluAdd   = 4'd2;
        localparam aluCtlT aluAnd   = 4'd3;
        localparam aluCtlT aluSub   = 4'd5;
        localparam aluCtlT aluXor   = 4'd8;
        localparam aluCtlT aluPassA = 4'd12;
        localparam aluCtlT aluNot   = 4'd13;

        // shifter codes, 6 to 8 pass B
        localparam bsCtlT bsNone = 4'd0;
        localparam bsCtlT bsAddr = 4'd1;
        localparam bsCtlT bsSll  = 4'd2;
        localparam bsCtlT bsSrl  = 4'd3;
        localparam bsCtlT bsSra  = 4'd4;
        localparam bsCtlT bsRol  = 4'd5;

        localparam rbCtlT rbNone   = 3'd0;
        localparam rbCtlT rbWrite  = 3'd1;
        localparam rbCtlT rbLoadIn = 3'd3;
        localparam rbCtlT rbClear  = 3'd5;

        localparam ioCtlT ioNone = 2'd0;
        localparam ioCtlT ioLed  = 2'd1;
        localparam ioCtlT ioSeg  = 2'd2;

        // operation ids with special handling
        localparam opIdT idBranch     = 7'd38;
        localparam opIdT idJumpMode   = 7'd72;
        localparam opIdT idBranchLink = 7'd73;
        localparam opIdT idHalt       = 7'd75;
        localparam opIdT idReset      = 7'd100;

endpackage

`default_nettype wire

/* source/instrDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
        input  wire                  clk,
        input  wire                  arstN,
        input  wire coreTypes::instrT instr,
        input  wire                  instrValid,
        input  wire                  zero,
        output coreTypes::opIdT      opId,
        output logic                 take,
        output logic                 halted,
        output coreTypes::regAddrT   rd,
        output coreTypes::regAddrT   rs,
        output coreTypes::regAddrT   rt,
        output coreTypes::wordT      imm
);

        coreTypes::instrT    instrQ;
        coreTypes::runStateT state;
        coreTypes::opIdT     newId;
        logic                latch;

        assign newId = instr[15:9];

        // strobes are ignored once halted, until reset
        assign latch = instrValid && (state != coreTypes::haltS);

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        instrQ <= {coreTypes::idReset, 9'd0};
                        take   <= 1'b0;
                        state  <= coreTypes::resetS;
                end else if (latch) begin
                        instrQ <= instr;
                        // branch condition uses zero as seen at latch time
                        take <= zero && (newId == coreTypes::idBranch ||
                                newId == coreTypes::idBranchLink);
                        if (newId == coreTypes::idHalt) begin
                                state <= coreTypes::haltS;
                        end else begin
                                state <= coreTypes::runS;
                        end
                end
        end

        assign halted = (state == coreTypes::haltS);

        // instruction fields
        assign opId = instrQ[15:9];
        assign rd   = instrQ[8:6];
        assign rs   = instrQ[5:3];
        assign rt   = instrQ[2:0];
        assign imm  = {13'd0, instrQ[2:0]};

endmodule

`default_nettype wire

/* source/controlCore.sv */
`timescale 1ns/10ps
`default_nettype none

module controlCore (
        input  wire coreTypes::opIdT opId,
        input  wire                  take,
        input  wire                  mode,
        output coreTypes::aluCtlT    controlALU,
        output coreTypes::bsCtlT     controlBS,
        output coreTypes::rbCtlT     controlRB,
        output coreTypes::seCtlT     controlSE1,
        output coreTypes::seCtlT     controlSE2,
        output coreTypes::mahCtlT    controlMAH,
        output coreTypes::mdhCtlT    controlMDH,
        output coreTypes::emCtlT     controlEM,
        output logic                 controlMUX,
        output coreTypes::ioCtlT     controlIO,
        output logic                 enable
);

        always_comb begin
                controlALU = coreTypes::aluPassA;
                controlBS  = coreTypes::bsNone;
                controlRB  = coreTypes::rbNone;
                controlSE1 = 3'd0;
                controlSE2 = 3'd0;
                controlMAH = 3'd0;
                controlMDH = 4'd0;
                controlEM  = 3'd0;
                controlMUX = 1'b0;
                controlIO  = coreTypes::ioNone;
                enable     = 1'b1;

                // alu
                case (opId) inside
                        4, 6, 10, 23, [28:30], [39:57], coreTypes::idBranchLink:
                                controlALU = coreTypes::aluAdd;
                        5, 7, 9, 11, 22, [31:33]: controlALU = coreTypes::aluSub;
                        12: controlALU = coreTypes::aluAnd;
                        13: controlALU = coreTypes::aluNot;
                        17: controlALU = coreTypes::aluOr;
                        18: controlALU = coreTypes::aluXor;
                        20: controlALU = 4'd14;
                        21: controlALU = 4'd6;
                        24: controlALU = 4'd7;
                        25: controlALU = 4'd9;
                        26: controlALU = 4'd4;
                        34: controlALU = 4'd10;
                        65: controlALU = 4'd11;
                        coreTypes::idBranch, [69:71], coreTypes::idReset:
                                controlALU = 4'd0;
                endcase

                // barrel shifter
                case (opId) inside
                        1, 14: controlBS = coreTypes::bsSrl;
                        2, 15: controlBS = coreTypes::bsSra;
                        3, 16: controlBS = coreTypes::bsSll;
                        19: controlBS = coreTypes::bsRol;
                        39, 56, 57, coreTypes::idBranchLink: controlBS = coreTypes::bsAddr;
                        63: controlBS = 4'd6;
                        64: controlBS = 4'd7;
                        66: controlBS = 4'd8;
                endcase

                // register bank, unlisted ids write nothing
                case (opId) inside
                        [1:37], 56, 57, [59:66]: controlRB = coreTypes::rbWrite;
                        39, [43:47], 49, 51, 53, 55, 68, 71:
                                controlRB = coreTypes::rbLoadIn;
                        58: controlRB = 3'd2;
                        coreTypes::idJumpMode: controlRB = mode ? coreTypes::rbNone : 3'd4;
                        coreTypes::idReset: controlRB = coreTypes::rbClear;
                endcase

                // sign extenders, SE1 is the lower one
                case (opId) inside
                        59: controlSE1 = 3'd1;
                        54, 55, 60, coreTypes::idBranchLink: controlSE1 = 3'd2;
                        61: controlSE1 = 3'd3;
                        62: controlSE1 = 3'd4;
                endcase
                case (opId) inside
                        47: controlSE2 = 3'd1;
                        43: controlSE2 = 3'd2;
                        45, 53, 71: controlSE2 = 3'd3;
                        46, 51: controlSE2 = 3'd4;
                endcase

                // memory address
                case (opId) inside
                        coreTypes::idBranch, coreTypes::idBranchLink:
                                controlMAH = take ? 3'd6 : 3'd0;
                        coreTypes::idJumpMode: controlMAH = 3'd6;
                        39, 40, 44, 48, 49, 54, 55: controlMAH = 3'd5;
                        41, 45, 47, 52, 53: controlMAH = 3'd4;
                        42, 43, 46, 50, 51: controlMAH = 3'd3;
                        67: controlMAH = 3'd1;
                        68: controlMAH = 3'd2;
                endcase

                // memory data
                case (opId) inside
                        42, 50: controlMDH = 4'd1;
                        41, 52: controlMDH = 4'd2;
                        40, 48, 54, 67: controlMDH = 4'd3;
                        43, 46, 51: controlMDH = 4'd4;
                        45, 47, 53, 71: controlMDH = 4'd5;
                        39, 44, 49, 55, 68: controlMDH = 4'd6;
                        69, 70: controlMDH = 4'd8;
                endcase

                // external memory
                case (opId) inside
                        42, 50: controlEM = 3'd1;
                        41, 52: controlEM = 3'd2;
                        40, 48, 54, 67: controlEM = 3'd3;
                        43, 44, 51: controlEM = 3'd4;
                        45, 53: controlEM = 3'd5;
                        39, 49, 55, 68: controlEM = 3'd6;
                        coreTypes::idReset: controlEM = 3'd7;
                endcase

                // operand mux picks the immediate
                case (opId) inside
                        [1:3], [6:11], 39, [48:57], coreTypes::idBranchLink:
                                controlMUX = 1'b1;
                        coreTypes::idJumpMode: controlMUX = !mode;
                endcase

                case (opId)
                        69: controlIO = coreTypes::ioSeg;
                        70: controlIO = coreTypes::ioLed;
                        coreTypes::idHalt: enable = 1'b0;
                        default: ;
                endcase

                // IO ids never write the register bank
                assert (controlIO == coreTypes::ioNone || controlRB == coreTypes::rbNone);
                assert (enable || opId == coreTypes::idHalt);
        end

endmodule

`default_nettype wire

/* source/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit (
        input  wire                     clk,
        input  wire                     arstN,
        input  wire coreTypes::aluCtlT  controlALU,
        input  wire coreTypes::bsCtlT   controlBS,
        input  wire coreTypes::rbCtlT   controlRB,
        input  wire                     controlMUX,
        input  wire coreTypes::ioCtlT   controlIO,
        input  wire                     halted,
        input  wire coreTypes::regAddrT rd,
        input  wire coreTypes::regAddrT rs,
        input  wire coreTypes::regAddrT rt,
        input  wire coreTypes::wordT    imm,
        input  wire coreTypes::wordT    dataIn,
        output coreTypes::wordT         ledOut,
        output coreTypes::wordT         segOut,
        output logic                    zero
);

        coreTypes::wordT [7:0] regFile;
        coreTypes::wordT       opA;
        coreTypes::wordT       opB;
        coreTypes::wordT       aluRes;
        coreTypes::wordT       bsRes;
        coreTypes::wordT       result;
        logic [3:0]            shamt;
        logic                  useShift;

        assign opA   = regFile[rs];
        assign opB   = controlMUX ? imm : regFile[rt];
        assign shamt = opB[3:0];

        always_comb begin
                case (controlALU)
                        coreTypes::aluOr:    aluRes = opA | opB;
                        coreTypes::aluAdd:   aluRes = opA + opB;
                        coreTypes::aluAnd:   aluRes = opA & opB;
                        coreTypes::aluSub:   aluRes = opA - opB;
                        coreTypes::aluXor:   aluRes = opA ^ opB;
                        coreTypes::aluNot:   aluRes = ~opA;
                        coreTypes::aluPassA: aluRes = opA;
                        default:             aluRes = opA;
                endcase
        end

        always_comb begin
                case (controlBS)
                        coreTypes::bsSll: bsRes = opA << shamt;
                        coreTypes::bsSrl: bsRes = opA >> shamt;
                        coreTypes::bsSra: bsRes = $signed(opA) >>> shamt;
                        coreTypes::bsRol: bsRes = (opA << shamt) | (opA >> (5'd16 - {1'b0, shamt}));
                        default:          bsRes = opB;
                endcase
        end

        assign useShift = controlBS inside {coreTypes::bsSll, coreTypes::bsSrl,
                coreTypes::bsSra, coreTypes::bsRol};
        assign result = useShift ? bsRes : aluRes;

        // register bank, cleared by the reset instruction
        always_ff @(posedge clk) begin
                if (!halted) begin
                        case (controlRB)
                                coreTypes::rbWrite:  regFile[rd] <= result;
                                coreTypes::rbLoadIn: regFile[rd] <= dataIn;
                                coreTypes::rbClear:  regFile <= '0;
                                default: ;
                        endcase
                end
        end

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        zero   <= 1'b0;
                        ledOut <= '0;
                        segOut <= '0;
                end else if (!halted) begin
                        if (controlRB == coreTypes::rbWrite) begin
                                zero <= (result == '0);
                        end
                        case (controlIO)
                                coreTypes::ioLed: ledOut <= opA;
                                coreTypes::ioSeg: segOut <= opA;
                                default: ;
                        endcase
                end
        end

        // once decode reports halt, nothing visible moves again
        haltFreeze: assert property (@(posedge clk) disable iff (!arstN)
                halted |=> $stable(regFile) && $stable(ledOut) && $stable(segOut));

endmodule

`default_nettype wire

/* source/cpuSlice.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuSlice (
        input  wire                   clk,
        input  wire                   arstN,
        input  wire coreTypes::instrT instr,
        input  wire                   instrValid,
        input  wire                   mode,
        input  wire coreTypes::wordT  dataIn,
        output coreTypes::wordT       ledOut,
        output coreTypes::wordT       segOut,
        output logic                  zero,
        output logic                  enable,
        output coreTypes::seCtlT      controlSE1,
        output coreTypes::seCtlT      controlSE2,
        output coreTypes::mahCtlT     controlMAH,
        output coreTypes::mdhCtlT     controlMDH,
        output coreTypes::emCtlT      controlEM
);

        coreTypes::opIdT    opId;
        logic               take;
        logic               halted;
        coreTypes::regAddrT rd;
        coreTypes::regAddrT rs;
        coreTypes::regAddrT rt;
        coreTypes::wordT    imm;
        coreTypes::aluCtlT  controlALU;
        coreTypes::bsCtlT   controlBS;
        coreTypes::rbCtlT   controlRB;
        logic               controlMUX;
        coreTypes::ioCtlT   controlIO;

        instrDecode u_instrDecode (
                .clk        (clk),
                .arstN      (arstN),
                .instr      (instr),
                .instrValid (instrValid),
                .zero       (zero),
                .opId       (opId),
                .take       (take),
                .halted     (halted),
                .rd         (rd),
                .rs         (rs),
                .rt         (rt),
                .imm        (imm)
        );

        controlCore u_controlCore (
                .opId       (opId),
                .take       (take),
                .mode       (mode),
                .controlALU (controlALU),
                .controlBS  (controlBS),
                .controlRB  (controlRB),
                .controlSE1 (controlSE1),
                .controlSE2 (controlSE2),
                .controlMAH (controlMAH),
                .controlMDH (controlMDH),
                .controlEM  (controlEM),
                .controlMUX (controlMUX),
                .controlIO  (controlIO),
                .enable     (enable)
        );

        execUnit u_execUnit (
                .clk        (clk),
                .arstN      (arstN),
                .controlALU (controlALU),
                .controlBS  (controlBS),
                .controlRB  (controlRB),
                .controlMUX (controlMUX),
                .controlIO  (controlIO),
                .halted     (halted),
                .rd         (rd),
                .rs         (rs),
                .rt         (rt),
                .imm        (imm),
                .dataIn     (dataIn),
                .ledOut     (ledOut),
                .segOut     (segOut),
                .zero       (zero)
        );

endmodule

`default_nettype wire

/* include/tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errorCount = 0;
int testCount = 0;
int failedTests = 0;
int errorsAtStart = 0;

task automatic beginTest();
        errorsAtStart = errorCount;
endtask

task automatic endTest(input string name);
        testCount++;
        if (errorCount == errorsAtStart) begin
                $display("test %s: ok", name);
        end else begin
                failedTests++;
                $display("test %s: %0d errors", name, errorCount - errorsAtStart);
        end
endtask

task automatic checkWord(input string name, input coreTypes::wordT got,
                input coreTypes::wordT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkAlu(input string name, input coreTypes::aluCtlT got,
                input coreTypes::aluCtlT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkRb(input string name, input coreTypes::rbCtlT got,
                input coreTypes::rbCtlT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkMah(input string name, input coreTypes::mahCtlT got,
                input coreTypes::mahCtlT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkSe(input string name, input coreTypes::seCtlT got,
                input coreTypes::seCtlT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkMdh(input string name, input coreTypes::mdhCtlT got,
                input coreTypes::mdhCtlT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkEm(input string name, input coreTypes::emCtlT got,
                input coreTypes::emCtlT want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

task automatic checkBit(input string name, input logic got, input logic want);
        if (got !== want) begin
                $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
                errorCount++;
        end
endtask

`endif

/* tests/cpuSlice_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuSlice_tb;

        // rough length of all tests in clock cycles
        localparam int testCycles = 300;

        logic                 clk;
        logic                 arstN;
        coreTypes::instrT     instr;
        logic                 instrValid;
        logic                 mode;
        coreTypes::wordT      dataIn;
        coreTypes::wordT      ledOut;
        coreTypes::wordT      segOut;
        logic                 zero;
        logic                 enable;
        coreTypes::seCtlT     controlSE1;
        coreTypes::seCtlT     controlSE2;
        coreTypes::mahCtlT    controlMAH;
        coreTypes::mdhCtlT    controlMDH;
        coreTypes::emCtlT     controlEM;
        logic [31:0]          lfsr;

        `include "tbChecks.svh"

        cpuSlice u_cpuSlice (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        initial begin
                #(testCycles * 40 * 2);
                $display("watchdog expired before the tests finished");
                $display("** FAIL **");
                $finish;
        end

        // taps 32, 22, 2, 1
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic randomBits(input int n, output coreTypes::wordT v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsrNext(lfsr);
                        v = {v[14:0], lfsr[0]};
                end
        endtask

        // kind is 0 srl, 1 sra, 2 sll or 3 rol
        // steps one bit at a time
        function automatic coreTypes::wordT shiftModel(input int kind,
                        input coreTypes::wordT a, input logic [3:0] n);
                coreTypes::wordT r;
                r = a;
                for (int i = 0; i < n; i++) begin
                        case (kind)
                                0: r = {1'b0, r[15:1]};
                                1: r = {r[15], r[15:1]};
                                2: r = {r[14:0], 1'b0};
                                default: r = {r[14:0], r[15]};
                        endcase
                end
                return r;
        endfunction

        function automatic coreTypes::instrT encode(input coreTypes::opIdT id,
                        input coreTypes::regAddrT rd, input coreTypes::regAddrT rs,
                        input coreTypes::regAddrT rt);
                return {id, rd, rs, rt};
        endfunction

        // one-cycle strobe that returns just after the latching edge
        task automatic issue(input coreTypes::instrT word);
                @(posedge clk);
                #2;
                instr = word;
                instrValid = 1'b1;
                @(posedge clk);
                #2;
                instrValid = 1'b0;
        endtask

        // second edge after the strobe updates the execute unit
        task automatic waitResult();
                @(posedge clk);
                @(negedge clk);
        endtask

        // dataIn follows one cycle late so the previous load keeps its value
        task automatic loadReg(input coreTypes::regAddrT rd, input coreTypes::wordT val);
                issue(encode(7'd71, rd, 3'd0, 3'd0));
                dataIn = val;
                @(posedge clk);
        endtask

        task automatic runAndShow(input coreTypes::instrT word,
                        input coreTypes::regAddrT rd, input coreTypes::wordT want);
                issue(word);
                waitResult();
                checkBit("zero", zero, want == 16'h0);
                issue(encode(7'd70, 3'd0, rd, 3'd0));
                waitResult();
                checkWord("ledOut", ledOut, want);
        endtask

        task automatic tableEntry(input coreTypes::opIdT id, input coreTypes::aluCtlT alu,
                        input coreTypes::rbCtlT rb, input coreTypes::mahCtlT mah,
                        input coreTypes::seCtlT se1, input coreTypes::seCtlT se2,
                        input coreTypes::mdhCtlT mdh, input coreTypes::emCtlT em);
                issue(encode(id, 3'd6, 3'd0, 3'd0));
                @(negedge clk);
                checkAlu("controlALU", u_cpuSlice.controlALU, alu);
                checkRb("controlRB", u_cpuSlice.controlRB, rb);
                checkMah("controlMAH", controlMAH, mah);
                checkSe("controlSE1", controlSE1, se1);
                checkSe("controlSE2", controlSE2, se2);
                checkMdh("controlMDH", controlMDH, mdh);
                checkEm("controlEM", controlEM, em);
                checkBit("enable", enable, 1'b1);
        endtask

        task automatic resetTest();
                beginTest();
                checkWord("ledOut", ledOut, 16'h0);
                checkWord("segOut", segOut, 16'h0);
                checkBit("zero", zero, 1'b0);
                for (int r = 0; r < 8; r++) begin
                        issue(encode(7'd70, 3'd0, coreTypes::regAddrT'(r), 3'd0));
                        waitResult();
                        checkWord("ledOut", ledOut, 16'h0);
                end
                endTest("reset");
        endtask

        task automatic arithTest();
                coreTypes::wordT a;
                coreTypes::wordT b;
                beginTest();
                for (int round = 0; round < 3; round++) begin
                        randomBits(16, a);
                        randomBits(16, b);
                        loadReg(3'd1, a);
                        loadReg(3'd2, b);
                        runAndShow(encode(7'd4, 3'd3, 3'd1, 3'd2), 3'd3, a + b);
                        runAndShow(encode(7'd5, 3'd4, 3'd1, 3'd2), 3'd4, a - b);
                        runAndShow(encode(7'd12, 3'd5, 3'd1, 3'd2), 3'd5, a & b);
                end
                endTest("arithmetic");
        endtask

        task automatic shiftTest();
                coreTypes::wordT a;
                coreTypes::wordT b;
                coreTypes::wordT k;
                beginTest();
                for (int round = 0; round < 2; round++) begin
                        randomBits(16, a);
                        randomBits(16, b);
                        loadReg(3'd1, a);
                        loadReg(3'd2, b);
                        runAndShow(encode(7'd14, 3'd3, 3'd1, 3'd2), 3'd3, shiftModel(0, a, b[3:0]));
                        runAndShow(encode(7'd15, 3'd3, 3'd1, 3'd2), 3'd3, shiftModel(1, a, b[3:0]));
                        runAndShow(encode(7'd16, 3'd3, 3'd1, 3'd2), 3'd3, shiftModel(2, a, b[3:0]));
                        runAndShow(encode(7'd19, 3'd3, 3'd1, 3'd2), 3'd3, shiftModel(3, a, b[3:0]));
                        // immediate sits in the rt field
                        randomBits(3, k);
                        runAndShow(encode(7'd1, 3'd3, 3'd1, k[2:0]), 3'd3, shiftModel(0, a, k[3:0]));
                        randomBits(3, k);
                        runAndShow(encode(7'd2, 3'd3, 3'd1, k[2:0]), 3'd3, shiftModel(1, a, k[3:0]));
                        randomBits(3, k);
                        runAndShow(encode(7'd3, 3'd3, 3'd1, k[2:0]), 3'd3, shiftModel(2, a, k[3:0]));
                end
                endTest("shift");
        endtask

        task automatic controlTableTest();
                beginTest();
                tableEntry(7'd39, coreTypes::aluAdd, coreTypes::rbLoadIn, 3'd5, 3'd0, 3'd0,
                        4'd6, 3'd6);
                tableEntry(7'd43, coreTypes::aluAdd, coreTypes::rbLoadIn, 3'd3, 3'd0, 3'd2,
                        4'd4, 3'd4);
                tableEntry(7'd67, coreTypes::aluPassA, coreTypes::rbNone, 3'd1, 3'd0, 3'd0,
                        4'd3, 3'd3);
                tableEntry(7'd69, 4'd0, coreTypes::rbNone, 3'd0, 3'd0, 3'd0,
                        4'd8, 3'd0);
                tableEntry(7'd55, coreTypes::aluAdd, coreTypes::rbLoadIn, 3'd5, 3'd2, 3'd0,
                        4'd6, 3'd6);
                endTest("control table");
        endtask

        task automatic condTest();
                coreTypes::wordT v;
                beginTest();
                randomBits(16, v);
                loadReg(3'd1, v | 16'h1);
                // r7 = r1 - r1 raises zero
                runAndShow(encode(7'd5, 3'd7, 3'd1, 3'd1), 3'd7, 16'h0);
                issue(encode(7'd38, 3'd0, 3'd0, 3'd0));
                @(negedge clk);
                checkMah("controlMAH", controlMAH, 3'd6);
                runAndShow(encode(7'd17, 3'd6, 3'd1, 3'd1), 3'd6, v | 16'h1);
                issue(encode(7'd38, 3'd0, 3'd0, 3'd0));
                @(negedge clk);
                checkMah("controlMAH", controlMAH, 3'd0);
                @(posedge clk);
                #2;
                mode = 1'b1;
                issue(encode(7'd72, 3'd0, 3'd0, 3'd0));
                @(negedge clk);
                checkRb("controlRB", u_cpuSlice.controlRB, coreTypes::rbNone);
                checkMah("controlMAH", controlMAH, 3'd6);
                @(posedge clk);
                #2;
                mode = 1'b0;
                @(negedge clk);
                checkRb("controlRB", u_cpuSlice.controlRB, 3'd4);
                endTest("conditional");
        endtask

        task automatic haltTest();
                coreTypes::wordT w;
                beginTest();
                randomBits(16, w);
                loadReg(3'd1, w);
                loadReg(3'd2, ~w);
                issue(encode(7'd70, 3'd0, 3'd1, 3'd0));
                waitResult();
                issue(encode(7'd69, 3'd0, 3'd1, 3'd0));
                waitResult();
                checkWord("segOut", segOut, w);
                issue(encode(7'd75, 3'd0, 3'd0, 3'd0));
                @(negedge clk);
                checkBit("enable", enable, 1'b0);
                // both strobes must be ignored
                issue(encode(7'd70, 3'd0, 3'd2, 3'd0));
                waitResult();
                issue(encode(7'd69, 3'd0, 3'd2, 3'd0));
                waitResult();
                checkWord("ledOut", ledOut, w);
                checkWord("segOut", segOut, w);
                checkBit("enable", enable, 1'b0);
                endTest("halt");
        endtask

        initial begin
                lfsr = 32'd87099;
                arstN = 1'b0;
                instr = '0;
                instrValid = 1'b0;
                mode = 1'b0;
                dataIn = '0;
                repeat (5) @(posedge clk);
                #2;
                arstN = 1'b1;
                @(negedge clk);
                resetTest();
                arithTest();
                shiftTest();
                controlTableTest();
                condTest();
                haltTest();
                $display("%0d tests, %0d failed, %0d check errors", testCount, failedTests,
                        errorCount);
                if (errorCount == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/coreTypes.sv
source/instrDecode.sv
source/controlCore.sv
source/execUnit.sv
source/cpuSlice.sv
tests/cpuSlice_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        -f verilog.f --top-module cpuSlice_tb -o cpuSliceSim

./obj_dir/cpuSliceSim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
        echo "simulation failed, see sim.log"
        exit 1
fi
echo "simulation passed"
